//--- design/cache_pkg.sv
package cache_pkg;

    // Address layout is tag | index | offset
    localparam int addr_w   = 14;
    localparam int tag_w    = 8;
    localparam int index_w  = 2;
    localparam int offset_w = 4;

    localparam int num_sets = 4;
    localparam int num_ways = 4;
    localparam int way_w    = 2;

    localparam int line_w   = 128;
    localparam int mask_w   = 16;
    localparam int age_w    = 2;

    // Requester opcodes
    typedef enum {
        op_read,
        op_write
    } cache_op_t;

    // Single outstanding miss
    typedef enum logic [2:0] {
        ms_idle,
        ms_writeback,
        ms_fill_req,
        ms_fill_wait,
        ms_refill
    } miss_state_t;

endpackage

//--- design/cache_request_decode.sv
`timescale 1ns/1ps

module cache_request_decode import cache_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_valid,
    input  cache_op_t          req_op,
    input  logic [addr_w-1:0]  req_addr,
    input  logic [line_w-1:0]  req_wdata,
    input  logic [mask_w-1:0]  req_mask,
    input  logic               stall,
    output logic               d_valid,
    output cache_op_t          d_op,
    output logic [tag_w-1:0]   d_tag,
    output logic [index_w-1:0] d_index,
    output logic [line_w-1:0]  d_wdata,
    output logic [mask_w-1:0]  d_mask
);

    // Valid bit freezes while a miss is pending
    always_ff @(posedge clk) begin
        if (reset) begin
            d_valid <= 1'b0;
        end else if (!stall) begin
            d_valid <= req_valid;
        end
    end

    // Offset bits are dropped, whole lines go back
    always_ff @(posedge clk) begin
        if (req_valid && !stall) begin
            d_op    <= req_op;
            d_tag   <= req_addr[addr_w-1 -: tag_w];
            d_index <= req_addr[offset_w +: index_w];
            d_wdata <= req_wdata;
            d_mask  <= req_mask;
        end
    end

endmodule

//--- design/cache_tag_meta_store.sv
`timescale 1ns/1ps

module cache_tag_meta_store import cache_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [index_w-1:0]             d_index,
    input  logic [tag_w-1:0]               d_tag,
    input  logic                           d_valid,
    input  cache_op_t                      d_op,
    input  logic                           meta_update,
    input  logic                           meta_fill,
    input  logic [way_w-1:0]               meta_way,
    input  logic                           meta_dirty,
    output logic [num_ways-1:0]            way_hit,
    output logic [num_ways-1:0]            way_valid,
    output logic [num_ways-1:0]            way_dirty,
    output logic [num_ways-1:0][age_w-1:0] way_ages,
    output logic [num_ways-1:0][tag_w-1:0] way_tags
);

    logic [tag_w-1:0]    tag_mem   [num_sets][num_ways];
    logic [age_w-1:0]    age_mem   [num_sets][num_ways];
    logic [num_ways-1:0] valid_mem [num_sets];
    logic [num_ways-1:0] dirty_mem [num_sets];

    logic [way_w-1:0] touch_way;
    logic [age_w-1:0] touch_age;

    // Four-way compare on the decoded set
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_tags[w]  = tag_mem[d_index][w];
            way_ages[w]  = age_mem[d_index][w];
            way_valid[w] = valid_mem[d_index][w];
            way_dirty[w] = dirty_mem[d_index][w];
            way_hit[w]   = d_valid && valid_mem[d_index][w] && (tag_mem[d_index][w] == d_tag);
        end
    end

    // Way made youngest by this access
    always_comb begin
        touch_way = meta_way;
        if (!meta_fill) begin
            for (int w = 0; w < num_ways; w++) begin
                if (way_hit[w]) begin
                    touch_way = way_w'(w);
                end
            end
        end
        touch_age = age_mem[d_index][touch_way];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
                for (int w = 0; w < num_ways; w++) begin
                    age_mem[s][w] <= age_w'(w);
                end
            end
        end else if (meta_fill || meta_update) begin
            // Younger ways slide up by one
            for (int w = 0; w < num_ways; w++) begin
                if (way_w'(w) == touch_way) begin
                    age_mem[d_index][w] <= '0;
                end else if (age_mem[d_index][w] < touch_age) begin
                    age_mem[d_index][w] <= age_mem[d_index][w] + 1'b1;
                end
            end
            if (meta_fill) begin
                valid_mem[d_index][meta_way] <= 1'b1;
                dirty_mem[d_index][meta_way] <= meta_dirty;
            end else if (d_op == op_write) begin
                dirty_mem[d_index][touch_way] <= 1'b1;
            end
        end
    end

    // Tag install on refill
    always_ff @(posedge clk) begin
        if (meta_fill) begin
            tag_mem[d_index][meta_way] <= d_tag;
        end
    end

endmodule

//--- design/cache_way_select.sv
`timescale 1ns/1ps

module cache_way_select import cache_pkg::*; (
    input  logic [num_ways-1:0]            way_hit,
    input  logic [num_ways-1:0]            way_valid,
    input  logic [num_ways-1:0]            way_dirty,
    input  logic [num_ways-1:0][age_w-1:0] way_ages,
    output logic                           hit,
    output logic [way_w-1:0]               hit_way,
    output logic [way_w-1:0]               victim_way,
    output logic                           victim_dirty
);

    logic found_invalid;

    assign hit = |way_hit;

    // At most one way matches
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (way_hit[w]) begin
                hit_way = way_w'(w);
            end
        end
    end

    // Lowest invalid way, else the oldest one
    always_comb begin
        found_invalid = 1'b0;
        victim_way    = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (!way_valid[w] && !found_invalid) begin
                victim_way    = way_w'(w);
                found_invalid = 1'b1;
            end
        end
        if (!found_invalid) begin
            for (int w = 0; w < num_ways; w++) begin
                if (way_ages[w] == age_w'(num_ways - 1)) begin
                    victim_way = way_w'(w);
                end
            end
        end
    end

    assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];

endmodule

//--- design/cache_miss_control.sv
`timescale 1ns/1ps

module cache_miss_control import cache_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           d_valid,
    input  cache_op_t                      d_op,
    input  logic [tag_w-1:0]               d_tag,
    input  logic [index_w-1:0]             d_index,
    input  logic                           hit,
    input  logic [way_w-1:0]               victim_way,
    input  logic                           victim_dirty,
    input  logic [num_ways-1:0][tag_w-1:0] way_tags,
    input  logic                           fill_valid,
    output logic                           stall,
    output logic                           busy,
    output logic                           meta_update,
    output logic                           meta_fill,
    output logic [way_w-1:0]               meta_way,
    output logic                           meta_dirty,
    output logic                           refill_we,
    output logic                           wb_valid,
    output logic [addr_w-1:0]              wb_addr,
    output logic                           fill_req,
    output logic [addr_w-1:0]              fill_addr
);

    miss_state_t state;
    miss_state_t state_next;

    logic                     miss;
    logic [way_w-1:0]         held_way;
    logic [tag_w+index_w-1:0] held_line_addr;
    logic                     held_write;

    assign miss = (state == ms_idle) && d_valid && !hit;

    always_comb begin
        state_next = state;
        case (state)
            ms_idle: begin
                if (miss) begin
                    state_next = victim_dirty ? ms_writeback : ms_fill_req;
                end
            end
            ms_writeback: begin
                state_next = ms_fill_req;
            end
            ms_fill_req: begin
                state_next = ms_fill_wait;
            end
            ms_fill_wait: begin
                if (fill_valid) begin
                    state_next = ms_refill;
                end
            end
            default: begin
                state_next = ms_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ms_idle;
        end else begin
            state <= state_next;
        end
    end

    // Victim snapshot at miss detection
    always_ff @(posedge clk) begin
        if (miss) begin
            held_way       <= victim_way;
            held_line_addr <= {way_tags[victim_way], d_index};
            held_write     <= (d_op == op_write);
        end
    end

    // Stall drops on the fill beat so decode clears its entry
    assign stall = miss || (state == ms_writeback) || (state == ms_fill_req)
                || ((state == ms_fill_wait) && !fill_valid);
    assign busy  = miss || (state != ms_idle);

    assign meta_update = (state == ms_idle) && d_valid && hit;
    assign meta_fill   = (state == ms_fill_wait) && fill_valid;
    assign meta_way    = held_way;
    assign meta_dirty  = held_write;
    assign refill_we   = (state == ms_fill_wait);

    assign wb_valid  = (state == ms_writeback);
    assign wb_addr   = {held_line_addr, {offset_w{1'b0}}};
    assign fill_req  = (state == ms_fill_req);
    assign fill_addr = {d_tag, d_index, {offset_w{1'b0}}};

endmodule

//--- design/cache_data_store.sv
`timescale 1ns/1ps

module cache_data_store import cache_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               d_valid,
    input  cache_op_t          d_op,
    input  logic [index_w-1:0] d_index,
    input  logic [line_w-1:0]  d_wdata,
    input  logic [mask_w-1:0]  d_mask,
    input  logic               hit,
    input  logic [way_w-1:0]   hit_way,
    input  logic [way_w-1:0]   victim_way,
    input  logic               refill_we,
    input  logic [line_w-1:0]  fill_line,
    input  logic               fill_valid,
    output logic               resp_valid,
    output logic               resp_hit,
    output logic [line_w-1:0]  resp_line,
    output logic [line_w-1:0]  victim_line
);

    logic [line_w-1:0] line_mem [num_sets][num_ways];

    logic              hit_access;
    logic              refill_access;
    logic [way_w-1:0]  access_way;
    logic [line_w-1:0] base_line;
    logic [line_w-1:0] merged_line;

    assign hit_access    = d_valid && hit;
    assign refill_access = refill_we && fill_valid;
    assign access_way    = refill_access ? victim_way : hit_way;
    assign base_line     = refill_access ? fill_line : line_mem[d_index][hit_way];

    // Feeds the writeback port
    assign victim_line = line_mem[d_index][victim_way];

    // Masked byte lanes replace the base line
    always_comb begin
        merged_line = base_line;
        if (d_op == op_write) begin
            for (int b = 0; b < mask_w; b++) begin
                if (d_mask[b]) begin
                    merged_line[8*b +: 8] = d_wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill_access || (hit_access && d_op == op_write)) begin
            line_mem[d_index][access_way] <= merged_line;
        end
        if (hit_access || refill_access) begin
            resp_line <= merged_line;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
            resp_hit   <= 1'b0;
        end else begin
            resp_valid <= hit_access || refill_access;
            resp_hit   <= hit_access;
        end
    end

endmodule

//--- design/cache_top.sv
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    input  cache_op_t         req_op,
    input  logic [addr_w-1:0] req_addr,
    input  logic [line_w-1:0] req_wdata,
    input  logic [mask_w-1:0] req_mask,
    output logic              busy,
    output logic              resp_valid,
    output logic              resp_hit,
    output logic [line_w-1:0] resp_line,
    output logic              wb_valid,
    output logic [addr_w-1:0] wb_addr,
    output logic [line_w-1:0] wb_line,
    output logic              fill_req,
    output logic [addr_w-1:0] fill_addr,
    input  logic              fill_valid,
    input  logic [line_w-1:0] fill_line
);

    // Decode stage
    logic               d_valid;
    cache_op_t          d_op;
    logic [tag_w-1:0]   d_tag;
    logic [index_w-1:0] d_index;
    logic [line_w-1:0]  d_wdata;
    logic [mask_w-1:0]  d_mask;
    logic               stall;

    // Lookup results
    logic [num_ways-1:0]            way_hit;
    logic [num_ways-1:0]            way_valid;
    logic [num_ways-1:0]            way_dirty;
    logic [num_ways-1:0][age_w-1:0] way_ages;
    logic [num_ways-1:0][tag_w-1:0] way_tags;
    logic                           hit;
    logic [way_w-1:0]               hit_way;
    logic [way_w-1:0]               victim_way;
    logic                           victim_dirty;

    // Miss sequencing
    logic             meta_update;
    logic             meta_fill;
    logic [way_w-1:0] meta_way;
    logic             meta_dirty;
    logic             refill_we;

    cache_request_decode decode_i (.*);

    cache_tag_meta_store tag_meta_i (.*);

    cache_way_select way_select_i (.*);

    cache_miss_control miss_control_i (.*);

    cache_data_store data_store_i (
        .victim_line (wb_line),
        .*
    );

endmodule

//--- verif/cache_props.sv
`timescale 1ns/1ps

module cache_props (
    input logic clk,
    input logic reset,
    input logic req_valid,
    input logic busy,
    input logic resp_valid,
    input logic resp_hit,
    input logic wb_valid,
    input logic fill_req
);

    // Set by a fill request, cleared by the response that ends the miss
    logic fill_seen;

    always_ff @(posedge clk) begin
        if (reset) begin
            fill_seen <= 1'b0;
        end else if (resp_valid) begin
            fill_seen <= 1'b0;
        end else if (fill_req) begin
            fill_seen <= 1'b1;
        end
    end

    fill_req_pulse: assert property (@(posedge clk) disable iff (reset) fill_req |=> !fill_req)
        else $error("fill_req longer than one cycle");

    wb_valid_pulse: assert property (@(posedge clk) disable iff (reset) wb_valid |=> !wb_valid)
        else $error("wb_valid longer than one cycle");

    no_req_when_busy: assert property (@(posedge clk) disable iff (reset) !(req_valid && busy))
        else $error("request strobed while busy");

    hit_without_fill: assert property (@(posedge clk) disable iff (reset)
        (resp_valid && resp_hit) |-> !fill_seen)
        else $error("hit response after a fill request");

    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (!resp_valid && !wb_valid && !fill_req && !busy))
        else $error("control output high after reset");

endmodule

bind cache_top cache_props props_i (.*);

//--- verif/cache_tb.sv
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

    // Longest test is well under 400 cycles
    localparam int max_cycles = 3000;

    logic              clk;
    logic              reset;
    logic              req_valid;
    cache_op_t         req_op;
    logic [addr_w-1:0] req_addr;
    logic [line_w-1:0] req_wdata;
    logic [mask_w-1:0] req_mask;
    logic              busy;
    logic              resp_valid;
    logic              resp_hit;
    logic [line_w-1:0] resp_line;
    logic              wb_valid;
    logic [addr_w-1:0] wb_addr;
    logic [line_w-1:0] wb_line;
    logic              fill_req;
    logic [addr_w-1:0] fill_addr;
    logic              fill_valid;
    logic [line_w-1:0] fill_line;

    integer seed = 32'h8c316969;
    int     errors = 0;
    int     cycle_count = 0;

    // Reference model of the cache contents
    logic [tag_w-1:0]  m_tag   [num_sets][num_ways];
    logic              m_valid [num_sets][num_ways];
    logic              m_dirty [num_sets][num_ways];
    logic [age_w-1:0]  m_age   [num_sets][num_ways];
    logic [line_w-1:0] m_line  [num_sets][num_ways];

    cache_top cache_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Memory contents seen through the fill port
    function automatic logic [line_w-1:0] fill_pattern(input logic [addr_w-1:0] line_addr);
        logic [line_w-1:0] line;
        for (int i = 0; i < 4; i++) begin
            line[32*i +: 32] = ({18'd0, line_addr} * 32'h0001_0003)
                             ^ (32'(i) * 32'h1111_1111) ^ 32'hc3a5_0f00;
        end
        return line;
    endfunction

    function automatic logic [line_w-1:0] merge_bytes(input logic [line_w-1:0] base,
                                                      input logic [line_w-1:0] wdata,
                                                      input logic [mask_w-1:0] mask);
        logic [line_w-1:0] line;
        line = base;
        for (int b = 0; b < mask_w; b++) begin
            if (mask[b]) begin
                line[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return line;
    endfunction

    function automatic int model_victim(input int set);
        for (int w = 0; w < num_ways; w++) begin
            if (!m_valid[set][w]) begin
                return w;
            end
        end
        for (int w = 0; w < num_ways; w++) begin
            if (m_age[set][w] == age_w'(num_ways - 1)) begin
                return w;
            end
        end
        return 0;
    endfunction

    task automatic model_reset();
        for (int s = 0; s < num_sets; s++) begin
            for (int w = 0; w < num_ways; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_age[s][w]   = age_w'(w);
            end
        end
    endtask

    // Accessed way becomes youngest, younger ways age by one
    task automatic model_touch(input int set, input int way);
        logic [age_w-1:0] old_age;
        old_age = m_age[set][way];
        for (int w = 0; w < num_ways; w++) begin
            if (w == way) begin
                m_age[set][w] = '0;
            end else if (m_age[set][w] < old_age) begin
                m_age[set][w] = m_age[set][w] + 1'b1;
            end
        end
    endtask

    task automatic report(input string msg);
        errors++;
        $display("FAILED t=%0t: %s", $time, msg);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (16) @(negedge clk);
        reset = 1'b0;
    endtask

    // Works out the expected outcome and advances the model
    task automatic predict(input cache_op_t op, input logic [addr_w-1:0] addr,
                           input logic [line_w-1:0] wdata, input logic [mask_w-1:0] mask,
                           output logic exp_hit, output logic exp_wb,
                           output logic [addr_w-1:0] exp_wb_addr,
                           output logic [line_w-1:0] exp_wb_line,
                           output logic [line_w-1:0] exp_line);
        int                set;
        int                way;
        logic [tag_w-1:0]  tag;
        logic [line_w-1:0] base;
        set = int'(addr[offset_w +: index_w]);
        tag = addr[addr_w-1 -: tag_w];
        exp_hit = 1'b0;
        way = model_victim(set);
        for (int w = 0; w < num_ways; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) begin
                exp_hit = 1'b1;
                way = w;
            end
        end
        exp_wb      = !exp_hit && m_valid[set][way] && m_dirty[set][way];
        exp_wb_addr = {m_tag[set][way], index_w'(set), {offset_w{1'b0}}};
        exp_wb_line = m_line[set][way];
        base = exp_hit ? m_line[set][way]
                       : fill_pattern({addr[addr_w-1:offset_w], {offset_w{1'b0}}});
        exp_line = (op == op_write) ? merge_bytes(base, wdata, mask) : base;
        m_line[set][way] = exp_line;
        if (!exp_hit) begin
            m_tag[set][way]   = tag;
            m_valid[set][way] = 1'b1;
            m_dirty[set][way] = (op == op_write);
        end else if (op == op_write) begin
            m_dirty[set][way] = 1'b1;
        end
        model_touch(set, way);
    endtask

    task automatic drive_request(input cache_op_t op, input logic [addr_w-1:0] addr,
                                 input logic [line_w-1:0] wdata, input logic [mask_w-1:0] mask);
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = wdata;
        req_mask  = mask;
    endtask

    // One request, played through writeback and fill until its response
    task automatic access(input cache_op_t op, input logic [addr_w-1:0] addr,
                          input logic [line_w-1:0] wdata, input logic [mask_w-1:0] mask,
                          output logic got_hit, output logic got_wb);
        logic              exp_hit;
        logic              exp_wb;
        logic              saw_fill;
        logic              done;
        logic [addr_w-1:0] exp_wb_addr;
        logic [addr_w-1:0] line_addr;
        logic [addr_w-1:0] mem_addr;
        logic [line_w-1:0] exp_wb_line;
        logic [line_w-1:0] exp_line;
        int                cycles;
        int                delay;
        predict(op, addr, wdata, mask, exp_hit, exp_wb, exp_wb_addr, exp_wb_line, exp_line);
        line_addr = {addr[addr_w-1:offset_w], {offset_w{1'b0}}};
        mem_addr = line_addr;
        got_hit = 1'b0;
        got_wb = 1'b0;
        saw_fill = 1'b0;
        done = 1'b0;
        delay = 0;
        while (busy) @(negedge clk);
        drive_request(op, addr, wdata, mask);
        @(negedge clk);
        req_valid = 1'b0;
        cycles = 1;
        while (!done) begin
            if (fill_valid) begin
                fill_valid = 1'b0;
            end else if (delay > 0) begin
                delay--;
                if (delay == 0) begin
                    fill_valid = 1'b1;
                    fill_line  = fill_pattern(mem_addr);
                end
            end
            if (wb_valid) begin
                got_wb = 1'b1;
                if (!exp_wb || saw_fill) begin
                    report($sformatf("unexpected writeback to %h", wb_addr));
                end else if (wb_addr != exp_wb_addr || wb_line != exp_wb_line) begin
                    report($sformatf("writeback %h/%h, expected %h/%h",
                                     wb_addr, wb_line, exp_wb_addr, exp_wb_line));
                end
            end
            if (fill_req) begin
                saw_fill = 1'b1;
                mem_addr = fill_addr;
                delay = 1 + int'($unsigned($random(seed)) % 32'd6);
                if (exp_hit) begin
                    report("fill request on an expected hit");
                end
                if (fill_addr != line_addr) begin
                    report($sformatf("fill address %h, expected %h", fill_addr, line_addr));
                end
                if (exp_wb && !got_wb) begin
                    report("fill request without the expected writeback");
                end
            end
            if (resp_valid) begin
                done = 1'b1;
                got_hit = resp_hit;
                if (resp_hit != exp_hit) begin
                    report($sformatf("resp_hit %b for %h, expected %b", resp_hit, addr, exp_hit));
                end
                if (resp_line != exp_line) begin
                    report($sformatf("resp_line %h, expected %h", resp_line, exp_line));
                end
                if (exp_hit && cycles != 2) begin
                    report($sformatf("hit latency %0d cycles, expected 2", cycles));
                end
                if (!exp_hit && !saw_fill) begin
                    report("miss response without a fill request");
                end
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    // Two reads on consecutive cycles, both expected to hit
    task automatic hit_pair(input logic [addr_w-1:0] addr_a, input logic [addr_w-1:0] addr_b);
        logic              hit_a;
        logic              hit_b;
        logic              wb;
        logic [addr_w-1:0] wb_a;
        logic [line_w-1:0] wl;
        logic [line_w-1:0] line_a;
        logic [line_w-1:0] line_b;
        predict(op_read, addr_a, '0, '0, hit_a, wb, wb_a, wl, line_a);
        predict(op_read, addr_b, '0, '0, hit_b, wb, wb_a, wl, line_b);
        while (busy) @(negedge clk);
        drive_request(op_read, addr_a, '0, '0);
        @(negedge clk);
        if (busy) begin
            req_valid = 1'b0;
            report("busy high after a read hit");
            return;
        end
        drive_request(op_read, addr_b, '0, '0);
        @(negedge clk);
        req_valid = 1'b0;
        if (!resp_valid || resp_hit != hit_a || resp_line != line_a) begin
            report($sformatf("first pair response %b/%b/%h", resp_valid, resp_hit, resp_line));
        end
        @(negedge clk);
        if (!resp_valid || resp_hit != hit_b || resp_line != line_b) begin
            report($sformatf("second pair response %b/%b/%h", resp_valid, resp_hit, resp_line));
        end
    endtask

    task automatic cold_read_miss();
        logic h;
        logic wb;
        access(op_read, 14'h0040, '0, '0, h, wb);
        if (h || wb) begin
            report("cold read did not miss without writeback");
        end
    endtask

    task automatic read_hits();
        logic h;
        logic wb;
        access(op_read, 14'h0048, '0, '0, h, wb);
        if (!h) begin
            report("read of a cached line missed");
        end
        access(op_read, 14'h0510, '0, '0, h, wb);
        access(op_read, 14'h0a20, '0, '0, h, wb);
        hit_pair(14'h0510, 14'h0a20);
    endtask

    task automatic masked_write_hit();
        logic h;
        logic wb;
        access(op_write, 14'h0044, 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210, 16'h0f31, h, wb);
        if (!h) begin
            report("write to a cached line missed");
        end
        access(op_read, 14'h0040, '0, '0, h, wb);
    endtask

    task automatic lru_eviction();
        logic h;
        logic wb;
        access(op_read, {8'h10, 2'b11, 4'h0}, '0, '0, h, wb);
        access(op_write, {8'h10, 2'b11, 4'h0}, {4{32'h5aa5_f00f}}, 16'hf0f0, h, wb);
        for (int t = 8'h11; t <= 8'h13; t++) begin
            access(op_read, {8'(t), 2'b11, 4'h0}, '0, '0, h, wb);
        end
        // Dirty line is now the oldest
        access(op_read, {8'h14, 2'b11, 4'h0}, '0, '0, h, wb);
        if (!wb) begin
            report("eviction of a dirty line gave no writeback");
        end
        access(op_read, {8'h10, 2'b11, 4'h0}, '0, '0, h, wb);
        if (h || wb) begin
            report("re-read of evicted line did not miss cleanly");
        end
    endtask

    task automatic write_miss();
        logic h;
        logic wb;
        int   wb_count;
        wb_count = 0;
        access(op_write, {8'h30, 2'b01, 4'h0}, {4{32'h1357_9bdf}}, 16'h00ff, h, wb);
        if (h) begin
            report("write to a new line hit");
        end
        access(op_read, {8'h30, 2'b01, 4'h0}, '0, '0, h, wb);
        for (int t = 8'h31; t <= 8'h34; t++) begin
            access(op_read, {8'(t), 2'b01, 4'h0}, '0, '0, h, wb);
            wb_count += int'(wb);
        end
        if (wb_count != 1) begin
            report($sformatf("%0d writebacks while evicting the written line", wb_count));
        end
    endtask

    task automatic reset_then_miss();
        logic h;
        logic wb;
        apply_reset();
        model_reset();
        access(op_read, 14'h0040, '0, '0, h, wb);
        if (h) begin
            report("read after reset hit");
        end
    endtask

    initial begin
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", max_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        reset      = 1'b1;
        req_valid  = 1'b0;
        req_op     = op_read;
        req_addr   = '0;
        req_wdata  = '0;
        req_mask   = '0;
        fill_valid = 1'b0;
        fill_line  = '0;
        model_reset();
        apply_reset();
        cold_read_miss();
        read_hits();
        masked_write_hit();
        lru_eviction();
        write_miss();
        reset_then_miss();
        repeat (2) @(negedge clk);
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
design/cache_pkg.sv
design/cache_request_decode.sv
design/cache_tag_meta_store.sv
design/cache_way_select.sv
design/cache_miss_control.sv
design/cache_data_store.sv
design/cache_top.sv
verif/cache_props.sv
verif/cache_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cache_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
